// ==== test/saturn_bus_vectors.txt ====
// op address count, all hex
// op 1 = load_pc, 2 = configure, 3 = read (count = reads), 0 = end
1 12345 00
3 00000 0a
2 abcde 00
3 00000 10
1 f0a5c 00
3 00000 20
2 00fff 00
3 00000 05
1 00001 00
3 00000 08
0 00000 00

// ==== saturn_bus_ctrl.f ====
+incdir+hw
hw/saturn_bus_cmd_pkg.sv
hw/saturn_bus_ctrl_pkg.sv
hw/saturn_bus_sequencer.sv
hw/saturn_bus_driver.sv
hw/saturn_bus_reader.sv
hw/saturn_bus_ctrl.sv
test/saturn_bus_ctrl_chk.sv
test/saturn_bus_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bus controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module saturn_bus_ctrl_tb \
  -f saturn_bus_ctrl.f -o sim_saturn_bus_ctrl

if ! ./obj_dir/sim_saturn_bus_ctrl > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  exit 1
fi
exit 0

// ==== test/saturn_bus_ctrl_tb.sv ====
// ******************************
// testbench for the nibble bus controller
// replays the vector file against the DUT
// models the bus device and counts errors
// ******************************

`timescale 1ns/1ps
`default_nettype none

`include "saturn_bus_defs.svh"

module saturn_bus_ctrl_tb;

  localparam int MAX_VEC    = 32;
  localparam int RST_CYCLES = 8;

  logic                         i_clk;
  logic                         cmd_RESET_0;
  logic                         i_cmd_load_pc;
  logic                         i_cmd_config;
  logic [`SATURN_ADDR_W-1:0]    i_address;
  logic                         i_alu_busy;
  logic [`SATURN_NIBBLE_W-1:0]  i_bus_data;
  wire                          o_bus_reset;
  wire                          o_bus_strobe;
  wire                          o_bus_cmd_data;
  wire [`SATURN_NIBBLE_W-1:0]   o_bus_data;
  wire                          o_stall_alu;
  wire [`SATURN_NIBBLE_W-1:0]   o_nibble;
  wire                          o_nibble_valid;

  // op then address then read count per line
  logic [`SATURN_ADDR_W-1:0]    vec_mem [0:3*MAX_VEC-1];

  // device side log of strobed nibbles
  logic [`SATURN_NIBBLE_W-1:0]  log_nib [$];
  logic                         log_lvl [$];
  logic [`SATURN_NIBBLE_W-1:0]  rd_expect [$];

  int   errors = 0;
  int   checks = 0;
  int   cyc = 0;
  int   cyc_limit = 100000;
  int   ph_next = 0;
  int   valid_cnt = 0;
  int   startup_strobes = 0;
  logic dev_reading = 1'b0;
  // set while a command owns the bus
  logic cmd_active = 1'b0;
  logic cyc_busy = 1'b1;

  saturn_bus_ctrl DUT (
    .i_clk          (i_clk),
    .cmd_RESET_0    (cmd_RESET_0),
    .i_cmd_load_pc  (i_cmd_load_pc),
    .i_cmd_config   (i_cmd_config),
    .i_address      (i_address),
    .i_alu_busy     (i_alu_busy),
    .i_bus_data     (i_bus_data),
    .o_bus_reset    (o_bus_reset),
    .o_bus_strobe   (o_bus_strobe),
    .o_bus_cmd_data (o_bus_cmd_data),
    .o_bus_data     (o_bus_data),
    .o_stall_alu    (o_stall_alu),
    .o_nibble       (o_nibble),
    .o_nibble_valid (o_nibble_valid)
  );

  // 10 ns clock
  initial i_clk = 1'b0;
  always #5 i_clk = ~i_clk;

  // watchdog
  always @(posedge i_clk) begin
    cyc <= cyc + 1;
    if (cyc > cyc_limit) begin
      $display("timeout: run did not finish within %0d clocks", cyc_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  function automatic void expect_val(input string name, input int exp, input int act);
    checks++;
    if (exp != act) begin
      errors++;
      $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
    end
  endfunction

  // device model stepped on every falling edge
  task automatic watch_bus();
    logic [`SATURN_NIBBLE_W-1:0] exp;
    if (o_bus_strobe) begin
      if (ph_next != 1) begin
        errors++;
        $display("strobe seen outside phase 1 of a bus cycle");
      end
      if (o_bus_reset) begin
        startup_strobes++;
      end else if (cmd_active) begin
        // every strobe of a command is logged with its level
        log_nib.push_back(o_bus_data);
        log_lvl.push_back(o_bus_cmd_data);
      end else if (dev_reading) begin
        if (cyc_busy) begin
          errors++;
          $display("read strobe in a bus cycle that began with the alu busy");
        end
        // fresh nibble held until the next read
        i_bus_data = 4'($urandom);
        rd_expect.push_back(i_bus_data);
      end else begin
        errors++;
        $display("strobe seen with no command in progress");
      end
    end
    if (o_nibble_valid) begin
      valid_cnt++;
      if (rd_expect.size() == 0) begin
        errors++;
        $display("nibble valid pulse with no read outstanding");
      end else begin
        exp = rd_expect.pop_front();
        expect_val("read_nibble", exp, o_nibble);
      end
    end
  endtask

  // one clock with the phase tracked from reset release
  task automatic tick();
    @(negedge i_clk);
    if (ph_next == 0) begin
      cyc_busy = i_alu_busy;
    end
    ph_next = (ph_next + 1) % `SATURN_PHASES;
    watch_bus();
  endtask

  task automatic send_cmd(input logic is_cfg, input logic [`SATURN_ADDR_W-1:0] addr,
                          input string name);
    int log_base;
    int stall_clks;
    int n_exp;
    logic [`SATURN_NIBBLE_W-1:0] exp_nib;
    logic exp_lvl;
    log_base   = log_nib.size();
    i_address  = addr;
    cmd_active = 1'b1;
    if (is_cfg) begin
      i_cmd_config = 1'b1;
    end else begin
      i_cmd_load_pc = 1'b1;
    end
    // accepted at the next phase 0
    while (!o_stall_alu) begin
      tick();
    end
    i_cmd_load_pc = 1'b0;
    i_cmd_config  = 1'b0;
    stall_clks = 1;
    while (o_stall_alu) begin
      tick();
      stall_clks++;
    end
    // both commands end in pc reads
    cmd_active  = 1'b0;
    dev_reading = 1'b1;
    // opcode and address cycles plus PC_READ for configure
    n_exp = `SATURN_ADDR_NIBBLES + 1 + (is_cfg ? 1 : 0);
    expect_val({name, "_stall_clks"}, n_exp * `SATURN_PHASES, stall_clks);
    expect_val({name, "_nibble_count"}, n_exp, log_nib.size() - log_base);
    if (log_nib.size() - log_base == n_exp) begin
      for (int i = 0; i < n_exp; i++) begin
        if (i == 0) begin
          exp_nib = is_cfg ? 4'(saturn_bus_cmd_pkg::BUSCMD_CONFIGURE) :
                             4'(saturn_bus_cmd_pkg::BUSCMD_LOAD_PC);
          exp_lvl = 1'b0;
        end else if (i <= `SATURN_ADDR_NIBBLES) begin
          // lowest nibble first
          exp_nib = 4'(addr >> (4 * (i - 1)));
          exp_lvl = 1'b1;
        end else begin
          exp_nib = 4'(saturn_bus_cmd_pkg::BUSCMD_PC_READ);
          exp_lvl = 1'b0;
        end
        expect_val($sformatf("%s_nib%0d", name, i), exp_nib, log_nib[log_base + i]);
        expect_val($sformatf("%s_lvl%0d", name, i), exp_lvl, log_lvl[log_base + i]);
      end
    end
  endtask

  task automatic collect_reads(input int n, input string name);
    int start_valid;
    int free_cycles;
    start_valid = valid_cnt;
    free_cycles = 0;
    while (free_cycles < n) begin
      tick();
      if (ph_next == 0) begin
        i_alu_busy = 1'($urandom);
        if (!i_alu_busy) begin
          free_cycles++;
        end
      end
    end
    // park the alu busy and let the last pulse through
    for (int i = 0; i < 2 * `SATURN_PHASES; i++) begin
      tick();
      if (ph_next == 0) begin
        i_alu_busy = 1'b1;
      end
    end
    expect_val({name, "_valid_count"}, free_cycles, valid_cnt - start_valid);
    expect_val({name, "_pending"}, 0, rd_expect.size());
  endtask

  initial begin
    int seed_val;
    int rel_clks;
    int units;
    int op;
    string name;
    seed_val = $urandom(32'he84e_2af5);
    cmd_RESET_0   = 1'b1;
    i_cmd_load_pc = 1'b0;
    i_cmd_config  = 1'b0;
    i_address     = '0;
    i_alu_busy    = 1'b1;
    i_bus_data    = '0;
    $readmemh("test/saturn_bus_vectors.txt", vec_mem);

    // run length in bus cycles with reads padded for busy gaps
    units = 0;
    for (int vi = 0; vi < MAX_VEC; vi++) begin
      op = int'(vec_mem[3*vi]);
      if (op == 0) begin
        break;
      end
      if (op == 1) begin
        units += `SATURN_ADDR_NIBBLES + 1;
      end else if (op == 2) begin
        units += `SATURN_ADDR_NIBBLES + 2;
      end else begin
        units += 4 * int'(vec_mem[3*vi+2]) + 2;
      end
    end
    cyc_limit = units * `SATURN_PHASES + RST_CYCLES + 200;

    repeat (RST_CYCLES) @(negedge i_clk);
    expect_val("reset_bus_reset", 1, o_bus_reset);
    expect_val("reset_stall", 1, o_stall_alu);
    expect_val("reset_strobe", 0, o_bus_strobe);
    expect_val("reset_valid", 0, o_nibble_valid);
    expect_val("reset_cmd_data", 0, o_bus_cmd_data);

    // next edge after release is phase 0
    cmd_RESET_0 = 1'b0;
    ph_next = 0;
    rel_clks = 0;
    while (o_bus_reset) begin
      tick();
      rel_clks++;
    end
    expect_val("startup_release_clks", 2, rel_clks);
    expect_val("startup_strobes", 1, startup_strobes);
    expect_val("startup_stall", 0, o_stall_alu);

    for (int vi = 0; vi < MAX_VEC; vi++) begin
      op = int'(vec_mem[3*vi]);
      if (op == 0) begin
        break;
      end
      if (op == 1) begin
        name = $sformatf("vec%0d_load_pc", vi);
        send_cmd(1'b0, vec_mem[3*vi+1], name);
      end else if (op == 2) begin
        name = $sformatf("vec%0d_configure", vi);
        send_cmd(1'b1, vec_mem[3*vi+1], name);
      end else begin
        name = $sformatf("vec%0d_read", vi);
        collect_reads(int'(vec_mem[3*vi+2]), name);
      end
    end

    $display("errors: %0d of %0d checks", errors, checks);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/saturn_bus_ctrl_chk.sv ====
// ******************************
// bus protocol assertions
// bound onto saturn_bus_ctrl,
// watches strobe, level and fsm state
// ******************************

`timescale 1ns/1ps
`default_nettype none

module saturn_bus_ctrl_chk (
  input wire                                  i_clk,
  input wire                                  cmd_RESET_0,
  input wire                                  i_bus_strobe,
  input wire                                  i_bus_cmd_data,
  input wire                                  i_alu_busy,
  input wire saturn_bus_ctrl_pkg::seq_state_e i_state
);

  // strobe covers phase 1 only
  a_strobe_one_clk: assert property (
    @(posedge i_clk) disable iff (cmd_RESET_0)
    i_bus_strobe |=> !i_bus_strobe
  ) else $error("bus strobe held for more than one clock");

  // level loaded at phase 0, must not move under the strobe
  a_level_stable: assert property (
    @(posedge i_clk) disable iff (cmd_RESET_0)
    i_bus_strobe |=> $stable(i_bus_cmd_data)
  ) else $error("cmd/data level changed while strobed");

  // busy alu holds reads off
  a_no_busy_read: assert property (
    @(posedge i_clk) disable iff (cmd_RESET_0)
    (i_state == saturn_bus_ctrl_pkg::ST_READING && i_alu_busy) |-> !i_bus_strobe
  ) else $error("read strobe while the alu is busy");

endmodule

bind saturn_bus_ctrl saturn_bus_ctrl_chk u_chk (
  .i_clk          (i_clk),
  .cmd_RESET_0    (cmd_RESET_0),
  .i_bus_strobe   (o_bus_strobe),
  .i_bus_cmd_data (o_bus_cmd_data),
  .i_alu_busy     (i_alu_busy),
  .i_state        (seq_state)
);

`default_nettype wire

// ==== hw/saturn_bus_ctrl.sv ====
// ******************************
// bus controller top level
// sequencer drives driver and reader
// external pins are loose ports
// ******************************

`timescale 1ns/1ps
`default_nettype none

`include "saturn_bus_defs.svh"

module saturn_bus_ctrl (
  input  wire                          i_clk,
  input  wire                          cmd_RESET_0,
  input  wire                          i_cmd_load_pc,
  input  wire                          i_cmd_config,
  input  wire [`SATURN_ADDR_W-1:0]     i_address,
  input  wire                          i_alu_busy,
  input  wire [`SATURN_NIBBLE_W-1:0]   i_bus_data,
  output wire                          o_bus_reset,
  output wire                          o_bus_strobe,
  output wire                          o_bus_cmd_data,
  output wire [`SATURN_NIBBLE_W-1:0]   o_bus_data,
  output wire                          o_stall_alu,
  output wire [`SATURN_NIBBLE_W-1:0]   o_nibble,
  output wire                          o_nibble_valid
);

  // sequencer to driver
  wire                                  drv_load;
  wire                                  drv_is_cmd;
  wire saturn_bus_cmd_pkg::bus_cmd_e    drv_opcode;
  wire [2:0]                            drv_ptr;
  // sequencer to reader
  wire                                  rd_capture;
  // fsm state, watched by the checker
  wire saturn_bus_ctrl_pkg::seq_state_e seq_state;

  saturn_bus_sequencer u_seq (
    .i_clk         (i_clk),
    .cmd_RESET_0   (cmd_RESET_0),
    .i_cmd_load_pc (i_cmd_load_pc),
    .i_cmd_config  (i_cmd_config),
    .i_alu_busy    (i_alu_busy),
    .o_bus_reset   (o_bus_reset),
    .o_bus_strobe  (o_bus_strobe),
    .o_stall_alu   (o_stall_alu),
    .o_drv_load    (drv_load),
    .o_drv_is_cmd  (drv_is_cmd),
    .o_drv_opcode  (drv_opcode),
    .o_drv_ptr     (drv_ptr),
    .o_rd_capture  (rd_capture),
    .o_state       (seq_state)
  );

  saturn_bus_driver u_drv (
    .i_clk          (i_clk),
    .cmd_RESET_0    (cmd_RESET_0),
    .i_drv_load     (drv_load),
    .i_drv_is_cmd   (drv_is_cmd),
    .i_drv_opcode   (drv_opcode),
    .i_drv_ptr      (drv_ptr),
    .i_address      (i_address),
    .o_bus_data     (o_bus_data),
    .o_bus_cmd_data (o_bus_cmd_data)
  );

  saturn_bus_reader u_rd (
    .i_clk          (i_clk),
    .cmd_RESET_0    (cmd_RESET_0),
    .i_rd_capture   (rd_capture),
    .i_bus_data     (i_bus_data),
    .o_nibble       (o_nibble),
    .o_nibble_valid (o_nibble_valid)
  );

endmodule

`default_nettype wire

// ==== hw/saturn_bus_reader.sv ====
// ******************************
// read capture register
// grabs the device nibble on rd_capture
// valid pulses one clock later
// ******************************

`timescale 1ns/1ps
`default_nettype none

`include "saturn_bus_defs.svh"

module saturn_bus_reader (
  input  wire                          i_clk,
  input  wire                          cmd_RESET_0,
  input  wire                          i_rd_capture,
  input  wire [`SATURN_NIBBLE_W-1:0]   i_bus_data,
  output logic [`SATURN_NIBBLE_W-1:0]  o_nibble,
  output logic                         o_nibble_valid
);

  // last read nibble, held between captures
  always_ff @(posedge i_clk) begin
    if (i_rd_capture) begin
      o_nibble <= i_bus_data;
    end
  end

  // single clock pulse per capture
  always_ff @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      o_nibble_valid <= 1'b0;
    end else begin
      o_nibble_valid <= i_rd_capture;
    end
  end

endmodule

`default_nettype wire

// ==== hw/saturn_bus_driver.sv ====
// ******************************
// bus output register
// loads an opcode or an address nibble
// plus the cmd/data level on drv_load
// and holds them until the next load
// ******************************

`timescale 1ns/1ps
`default_nettype none

`include "saturn_bus_defs.svh"

module saturn_bus_driver (
  input  wire                                i_clk,
  input  wire                                cmd_RESET_0,
  input  wire                                i_drv_load,
  input  wire                                i_drv_is_cmd,
  input  wire saturn_bus_cmd_pkg::bus_cmd_e  i_drv_opcode,
  input  wire [2:0]                          i_drv_ptr,
  input  wire [`SATURN_ADDR_W-1:0]           i_address,
  output logic [`SATURN_NIBBLE_W-1:0]        o_bus_data,
  output logic                               o_bus_cmd_data
);

  logic [`SATURN_NIBBLE_W-1:0] addr_nib;

  // address nibble picked by the sequencer pointer
  // ptr 0 is the lowest nibble
  assign addr_nib = i_address[i_drv_ptr * `SATURN_NIBBLE_W +: `SATURN_NIBBLE_W];

  // nibble payload
  always_ff @(posedge i_clk) begin
    if (i_drv_load) begin
      if (i_drv_is_cmd) begin
        o_bus_data <= i_drv_opcode;
      end else begin
        o_bus_data <= addr_nib;
      end
    end
  end

  // level: low for opcodes, high for anything else
  always_ff @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      o_bus_cmd_data <= 1'b0;
    end else if (i_drv_load) begin
      o_bus_cmd_data <= !i_drv_is_cmd;
    end
  end

endmodule

`default_nettype wire

// ==== hw/saturn_bus_sequencer.sv ====
// ******************************
// control half of the bus controller
// counts bus phases, runs the command FSM,
// owns strobe, stall and nibble selection
// driver and reader follow its pulses
// ******************************

`timescale 1ns/1ps
`default_nettype none

`include "saturn_bus_defs.svh"

module saturn_bus_sequencer (
  input  wire                                i_clk,
  input  wire                                cmd_RESET_0,
  input  wire                                i_cmd_load_pc,
  input  wire                                i_cmd_config,
  input  wire                                i_alu_busy,
  output logic                               o_bus_reset,
  output logic                               o_bus_strobe,
  output logic                               o_stall_alu,
  output logic                               o_drv_load,
  output logic                               o_drv_is_cmd,
  output saturn_bus_cmd_pkg::bus_cmd_e       o_drv_opcode,
  output logic [2:0]                         o_drv_ptr,
  output logic                               o_rd_capture,
  output saturn_bus_ctrl_pkg::seq_state_e    o_state
);

  localparam int PH_W = $clog2(`SATURN_PHASES);
  localparam logic [PH_W-1:0] PH_LAST = PH_W'(`SATURN_PHASES - 1);
  // ptr value once every address nibble is out
  localparam logic [2:0] PTR_END = 3'(`SATURN_ADDR_NIBBLES);

  logic [PH_W-1:0]                 phase;
  saturn_bus_ctrl_pkg::seq_state_e state;
  saturn_bus_cmd_pkg::bus_cmd_e    cur_cmd;
  saturn_bus_cmd_pkg::bus_cmd_e    acc_cmd;
  logic [2:0]                      ptr;

  logic ph0;
  logic ph1;
  logic ph3;
  logic can_accept;
  logic accept;
  logic start_go;
  logic loop_send;
  logic loop_done;
  logic pcr_send;
  logic read_go;
  logic xfer_go;

  // phase decode
  assign ph0 = (phase == '0);
  assign ph1 = (phase == PH_W'(1));
  assign ph3 = (phase == PH_LAST);

  // commands only land between transfers
  assign can_accept = (state == saturn_bus_ctrl_pkg::ST_IDLE) ||
                      (state == saturn_bus_ctrl_pkg::ST_READING);
  assign accept     = ph0 && can_accept && (i_cmd_load_pc || i_cmd_config);

  // load_pc wins if both are up
  always_comb begin
    if (i_cmd_load_pc) begin
      acc_cmd = saturn_bus_cmd_pkg::BUSCMD_LOAD_PC;
    end else begin
      acc_cmd = saturn_bus_cmd_pkg::BUSCMD_CONFIGURE;
    end
  end

  // per-cycle transfer kinds, all decided at phase 0
  assign start_go  = ph0 && (state == saturn_bus_ctrl_pkg::ST_BUS_RESET);
  assign loop_send = ph0 && (state == saturn_bus_ctrl_pkg::ST_ADDR_LOOP) && (ptr < PTR_END);
  assign pcr_send  = ph0 && (state == saturn_bus_ctrl_pkg::ST_SEND_PC_READ);
  // read only if the alu is not busy at phase 0
  assign read_go   = ph0 && (state == saturn_bus_ctrl_pkg::ST_READING) && !accept &&
                     !i_alu_busy;
  assign xfer_go   = start_go || accept || loop_send || pcr_send || read_go;

  // last address nibble went out this cycle
  assign loop_done = ph3 && (state == saturn_bus_ctrl_pkg::ST_ADDR_LOOP) && (ptr == PTR_END);

  // driver side, sampled on the phase 0 edge
  // startup strobe carries no nibble
  assign o_drv_load   = accept || loop_send || pcr_send || read_go;
  assign o_drv_is_cmd = accept || pcr_send;
  assign o_drv_ptr    = ptr;

  always_comb begin
    if (pcr_send) begin
      o_drv_opcode = saturn_bus_cmd_pkg::BUSCMD_PC_READ;
    end else begin
      o_drv_opcode = acc_cmd;
    end
  end

  // device answers while the read strobe is up
  assign o_rd_capture = ph1 && o_bus_strobe && (state == saturn_bus_ctrl_pkg::ST_READING);
  assign o_state      = state;

  // free running phase counter
  always_ff @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      phase <= '0;
    end else if (ph3) begin
      phase <= '0;
    end else begin
      phase <= phase + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      state        <= saturn_bus_ctrl_pkg::ST_BUS_RESET;
      cur_cmd      <= saturn_bus_cmd_pkg::BUSCMD_PC_READ;
      ptr          <= '0;
      o_bus_strobe <= 1'b0;
      o_bus_reset  <= 1'b1;
      o_stall_alu  <= 1'b1;
    end else begin
      // strobe set on phase 0 edge, so it covers phase 1 only
      o_bus_strobe <= xfer_go;
      case (state)
        saturn_bus_ctrl_pkg::ST_BUS_RESET: begin
          // release after the empty startup strobe
          if (ph1) begin
            o_bus_reset <= 1'b0;
            o_stall_alu <= 1'b0;
            state       <= saturn_bus_ctrl_pkg::ST_IDLE;
          end
        end
        saturn_bus_ctrl_pkg::ST_IDLE,
        saturn_bus_ctrl_pkg::ST_READING: begin
          if (accept) begin
            cur_cmd     <= acc_cmd;
            ptr         <= '0;
            o_stall_alu <= 1'b1;
            state       <= saturn_bus_ctrl_pkg::ST_ADDR_LOOP;
          end
        end
        saturn_bus_ctrl_pkg::ST_ADDR_LOOP: begin
          // ptr counts nibbles already sent
          if (loop_send) begin
            ptr <= ptr + 3'd1;
          end
          if (loop_done) begin
            ptr <= '0;
            if (cur_cmd == saturn_bus_cmd_pkg::BUSCMD_CONFIGURE) begin
              state <= saturn_bus_ctrl_pkg::ST_SEND_PC_READ;
            end else begin
              // load_pc switches to pc reads on its own
              o_stall_alu <= 1'b0;
              state       <= saturn_bus_ctrl_pkg::ST_READING;
            end
          end
        end
        saturn_bus_ctrl_pkg::ST_SEND_PC_READ: begin
          // PC_READ opcode went out at phase 0
          if (ph3) begin
            o_stall_alu <= 1'b0;
            state       <= saturn_bus_ctrl_pkg::ST_READING;
          end
        end
        default: begin
          state <= saturn_bus_ctrl_pkg::ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/saturn_bus_ctrl_pkg.sv ====
// ******************************
// state encoding of the bus sequencer
// also seen by the checker via o_state
// ******************************

`default_nettype none

package saturn_bus_ctrl_pkg;

  // bus release, idle, address loop,
  // trailing PC_READ after configure, reading
  typedef enum logic [2:0] {
    ST_BUS_RESET,
    ST_IDLE,
    ST_ADDR_LOOP,
    ST_SEND_PC_READ,
    ST_READING
  } seq_state_e;

endpackage

`default_nettype wire

// ==== hw/saturn_bus_cmd_pkg.sv ====
// ******************************
// opcodes as they appear on the bus
// sent with o_bus_cmd_data low
// ******************************

`default_nettype none

`include "saturn_bus_defs.svh"

package saturn_bus_cmd_pkg;

  // one nibble wide, same as a bus transfer
  typedef enum logic [`SATURN_NIBBLE_W-1:0] {
    BUSCMD_PC_READ   = 4'h0,
    BUSCMD_LOAD_PC   = 4'h4,
    BUSCMD_CONFIGURE = 4'h5
  } bus_cmd_e;

endpackage

`default_nettype wire

// ==== hw/saturn_bus_defs.svh ====
// ******************************
// sizing macros for the nibble bus
// include wherever a width, the address
// nibble count or the phase count is needed
// ******************************

`ifndef SATURN_BUS_DEFS_SVH
`define SATURN_BUS_DEFS_SVH

// one bus transfer is a nibble
`define SATURN_NIBBLE_W 4

// full address, pc or config target
`define SATURN_ADDR_W 20

// nibbles sent after LOAD_PC / CONFIGURE
// lowest nibble goes first
`define SATURN_ADDR_NIBBLES 5

// clocks per bus cycle
// phase 0 load, phase 1 strobe, 2 and 3 idle
`define SATURN_PHASES 4

`endif
